/* rtl/pixel_pkg.sv */
`default_nettype none

package pixel_pkg;

    localparam int PIX_W = 8;
    localparam int WIN_ROWS = 5;
    localparam int BLK_OUT = 3;                    // also the block stride in columns

    // default geometry, four overlapping 5x5 blocks per window
    localparam int DEF_BLOCKS = 4;
    localparam int DEF_COLS = BLK_OUT * DEF_BLOCKS + 2;

    typedef logic [PIX_W-1:0] pix_t;

    // row 0 first, column 0 in the top pixel of each row
    typedef pix_t [WIN_ROWS*DEF_COLS-1:0] window_t;

    // output (0,0) on top, row-major
    typedef pix_t [BLK_OUT*BLK_OUT-1:0] block_t;

    typedef block_t [DEF_BLOCKS-1:0] blockset_t;   // block 0 on top

    function automatic pix_t median3(
        input pix_t a,
        input pix_t b,
        input pix_t c
    );
        pix_t lo;
        pix_t hi;
        lo = (a < b) ? a : b;
        hi = (a < b) ? b : a;
        if (c <= lo) begin
            return lo;
        end
        if (c >= hi) begin
            return hi;
        end
        return c;
    endfunction

endpackage

`default_nettype wire

/* rtl/flow_pkg.sv */
`default_nettype none

package flow_pkg;

    localparam int CREDIT_W = 4;
    localparam int PTR_W = 3;            // address bits plus wrap bit

    // output credits held toward the consumer
    typedef logic [CREDIT_W-1:0] credit_t;

    // result FIFO pointer, MSB tells full from empty
    typedef logic [PTR_W-1:0] ptr_t;

endpackage

`default_nettype wire

/* rtl/result_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module result_fifo #(
    parameter int NUM_BLOCKS = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic clk,
    input  logic fifo_we,
    input  flow_pkg::ptr_t wr_ptr,
    input  flow_pkg::ptr_t rd_ptr,
    input  pixel_pkg::block_t [NUM_BLOCKS-1:0] blocks,
    output pixel_pkg::block_t [NUM_BLOCKS-1:0] block_out
);
    import pixel_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    block_t [NUM_BLOCKS-1:0] mem [FIFO_DEPTH];
    logic                    not_empty;

    assign not_empty = (rd_ptr != wr_ptr);

    always_ff @(posedge clk) begin
        if (fifo_we) begin
            mem[wr_ptr[AW-1:0]] <= blocks;
        end
    end

    // head entry is loaded at the pop edge, same edge as out_valid
    // and holds once the FIFO runs empty
    always_ff @(posedge clk) begin
        if (not_empty) begin
            block_out <= mem[rd_ptr[AW-1:0]];
        end
    end

endmodule

`default_nettype wire

/* rtl/row_median_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module row_median_stage #(
    parameter int NUM_BLOCKS = 4
) (
    input  logic clk,
    input  logic row_en,
    input  pixel_pkg::pix_t [pixel_pkg::WIN_ROWS*(pixel_pkg::BLK_OUT*NUM_BLOCKS+2)-1:0] pix_in,
    output pixel_pkg::pix_t row_med [pixel_pkg::WIN_ROWS][pixel_pkg::BLK_OUT*NUM_BLOCKS]
);
    import pixel_pkg::*;

    localparam int WIN_COLS = BLK_OUT * NUM_BLOCKS + 2;
    localparam int NUM_POS = BLK_OUT * NUM_BLOCKS;     // distinct horizontal triples
    localparam int NUM_PIX = WIN_ROWS * WIN_COLS;

    pix_t win [WIN_ROWS][WIN_COLS];

    // unpack, pixel (0,0) sits at the top of the vector
    always_comb begin
        for (int r = 0; r < WIN_ROWS; r++) begin
            for (int c = 0; c < WIN_COLS; c++) begin
                win[r][c] = pix_in[NUM_PIX-1-(r*WIN_COLS+c)];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_en) begin
            for (int r = 0; r < WIN_ROWS; r++) begin
                for (int c = 0; c < NUM_POS; c++) begin
                    row_med[r][c] <= median3(win[r][c], win[r][c+1], win[r][c+2]);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/col_median_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module col_median_stage #(
    parameter int NUM_BLOCKS = 4
) (
    input  logic clk,
    input  logic col_en,
    input  pixel_pkg::pix_t row_med [pixel_pkg::WIN_ROWS][pixel_pkg::BLK_OUT*NUM_BLOCKS],
    output pixel_pkg::block_t [NUM_BLOCKS-1:0] blocks
);
    import pixel_pkg::*;

    localparam int BLK_PIX = BLK_OUT * BLK_OUT;

    // output (r,c) of block k takes rows r..r+2 at position 3k+c
    always_ff @(posedge clk) begin
        if (col_en) begin
            for (int k = 0; k < NUM_BLOCKS; k++) begin
                for (int r = 0; r < BLK_OUT; r++) begin
                    for (int c = 0; c < BLK_OUT; c++) begin
                        blocks[NUM_BLOCKS-1-k][BLK_PIX-1-(r*BLK_OUT+c)] <= median3(
                            row_med[r][BLK_OUT*k+c],
                            row_med[r+1][BLK_OUT*k+c],
                            row_med[r+2][BLK_OUT*k+c]
                        );
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/denoise_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module denoise_ctrl (
    input  logic clk,
    input  logic rst_n,

    input  logic in_valid,
    input  logic out_credit,

    // stage and FIFO control
    output logic row_en,
    output logic col_en,
    output logic fifo_we,
    output flow_pkg::ptr_t wr_ptr,
    output flow_pkg::ptr_t rd_ptr,

    output logic out_valid,
    output logic in_credit
);
    import flow_pkg::*;

    logic    valid_row;       // window held in the row stage
    logic    valid_col;       // window held in the col stage
    credit_t credits;
    logic    credit_full;
    logic    fifo_empty;
    logic    pop;

    assign row_en = in_valid;
    assign col_en = valid_row;
    assign fifo_we = valid_col;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign credit_full = &credits;
    assign pop = !fifo_empty && (credits != '0);

    // valid pipe, follows the data through both median stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_row <= 1'b0;
            valid_col <= 1'b0;
        end else begin
            valid_row <= in_valid;
            valid_col <= valid_row;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (fifo_we) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // grants past the counter range are dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= '0;
        end else if (out_credit && !pop) begin
            if (!credit_full) begin
                credits <= credits + 1'b1;
            end
        end else if (pop && !out_credit) begin
            credits <= credits - 1'b1;
        end
    end

    // a leaving result frees one FIFO slot upstream
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            out_valid <= pop;
            in_credit <= pop;
        end
    end

endmodule

`default_nettype wire

/* rtl/denoise_top.sv */
`timescale 1ns/10ps
`default_nettype none

module denoise_top #(
    parameter int NUM_BLOCKS = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic clk,
    input  logic rst_n,

    // upstream, credit based
    input  logic in_valid,
    input  pixel_pkg::pix_t [pixel_pkg::WIN_ROWS*(pixel_pkg::BLK_OUT*NUM_BLOCKS+2)-1:0] pix_in,
    output logic in_credit,

    // downstream, credit based
    input  logic out_credit,
    output logic out_valid,
    output pixel_pkg::block_t [NUM_BLOCKS-1:0] block_out
);
    import pixel_pkg::*;
    import flow_pkg::*;

    logic row_en;
    logic col_en;
    logic fifo_we;
    ptr_t wr_ptr;
    ptr_t rd_ptr;

    pix_t row_med [WIN_ROWS][BLK_OUT*NUM_BLOCKS];   // shared across the blocks
    block_t [NUM_BLOCKS-1:0] blocks;

    denoise_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .out_credit (out_credit),
        .row_en     (row_en),
        .col_en     (col_en),
        .fifo_we    (fifo_we),
        .wr_ptr     (wr_ptr),
        .rd_ptr     (rd_ptr),
        .out_valid  (out_valid),
        .in_credit  (in_credit)
    );

    row_median_stage #(
        .NUM_BLOCKS (NUM_BLOCKS)
    ) u_row (
        .clk     (clk),
        .row_en  (row_en),
        .pix_in  (pix_in),
        .row_med (row_med)
    );

    col_median_stage #(
        .NUM_BLOCKS (NUM_BLOCKS)
    ) u_col (
        .clk     (clk),
        .col_en  (col_en),
        .row_med (row_med),
        .blocks  (blocks)
    );

    result_fifo #(
        .NUM_BLOCKS (NUM_BLOCKS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .fifo_we   (fifo_we),
        .wr_ptr    (wr_ptr),
        .rd_ptr    (rd_ptr),
        .blocks    (blocks),
        .block_out (block_out)
    );

endmodule

`default_nettype wire

/* test/tb_denoise_ref.svh */
`ifndef TB_DENOISE_REF_SVH
`define TB_DENOISE_REF_SVH

// middle value by a three-step sorting network
function automatic pix_t mid_of_three(input pix_t a, input pix_t b, input pix_t c);
    pix_t x;
    pix_t y;
    pix_t z;
    pix_t t;
    x = a;
    y = b;
    z = c;
    if (x > y) begin
        t = x;
        x = y;
        y = t;
    end
    if (y > z) begin
        t = y;
        y = z;
        z = t;
    end
    if (x > y) begin
        y = x;
    end
    return y;
endfunction

function automatic pix_t pixel_at(input window_t w, input int row, input int col);
    return w[WIN_PIX-1-(row*WIN_COLS+col)];   // (0,0) is the top pixel
endfunction

// separable 3x3 median for every block, block k starts at column 3k
function automatic blockset_t ref_denoise(input window_t w);
    blockset_t bs;
    pix_t      rm [3];
    int        col;
    for (int k = 0; k < NUM_BLOCKS; k++) begin
        for (int r = 0; r < BLK_OUT; r++) begin
            for (int c = 0; c < BLK_OUT; c++) begin
                col = BLK_OUT * k + c;
                for (int i = 0; i < 3; i++) begin
                    rm[i] = mid_of_three(pixel_at(w, r + i, col),
                                         pixel_at(w, r + i, col + 1),
                                         pixel_at(w, r + i, col + 2));
                end
                bs[NUM_BLOCKS-1-k][BLK_OUT*BLK_OUT-1-(r*BLK_OUT+c)] =
                    mid_of_three(rm[0], rm[1], rm[2]);
            end
        end
    end
    return bs;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

task automatic check_block(input string name, input blockset_t got, input blockset_t exp);
    if (got !== exp) begin
        $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        stop_on_error();
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got !== exp) begin
        $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        stop_on_error();
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        stop_on_error();
    end
endtask

`endif

/* test/tb_denoise.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_denoise;
    import pixel_pkg::*;

    localparam int NUM_BLOCKS = 4;
    localparam int FIFO_DEPTH = 4;
    localparam int WIN_COLS = BLK_OUT * NUM_BLOCKS + 2;
    localparam int WIN_PIX = WIN_ROWS * WIN_COLS;
    localparam int MAX_GRANTS = 12;                 // stays below the DUT credit ceiling
    localparam int NUM_RANDOM = 200;
    localparam int NUM_GAPPED = 100;
    localparam int TOTAL_WINDOWS = 3 + NUM_RANDOM + FIFO_DEPTH + NUM_GAPPED;
    localparam int WATCHDOG_CYCLES = (TOTAL_WINDOWS + 20) * 20;

    localparam int GRANT_NONE = 0;
    localparam int GRANT_ALWAYS = 1;
    localparam int GRANT_RANDOM = 2;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    window_t   pix_in;
    logic      in_credit;
    logic      out_credit;
    logic      out_valid;
    blockset_t block_out;

    blockset_t   exp_q [$];
    logic [31:0] rng_state = 32'h79e2;
    int          grant_mode = GRANT_NONE;
    logic        grant_once = 1'b0;
    int          windows_sent = 0;     // stimulus side counts
    int          grants_issued = 0;
    int          valid_count = 0;      // monitor side counts
    int          in_credit_count = 0;
    int          grants_seen = 0;

    denoise_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .pix_in     (pix_in),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .block_out  (block_out)
    );

    task automatic stop_on_error();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic fail_with(input string msg);
        $display("ERROR %s", msg);
        stop_on_error();
    endtask

    `include "tb_denoise_ref.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        stop_on_error();
    end

    task automatic next_rand();
        rng_state = xorshift32(rng_state);
    endtask

    task automatic drive_out_credit();
        logic give;
        give = 1'b0;
        if (grant_once) begin
            give = 1'b1;
            grant_once = 1'b0;
        end else if (grants_issued - valid_count < MAX_GRANTS) begin
            case (grant_mode)
                GRANT_ALWAYS: give = 1'b1;
                GRANT_RANDOM: begin
                    next_rand();
                    give = rng_state[0];
                end
                default: give = 1'b0;
            endcase
        end
        out_credit = give;
        if (give) begin
            grants_issued++;
        end
    endtask

    // all driving happens here, on the falling edge
    task automatic next_cycle();
        @(negedge clk);
        drive_out_credit();
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        in_valid = 1'b0;
        grant_mode = GRANT_NONE;
        repeat (3) next_cycle();
        windows_sent = 0;
        grants_issued = 0;
        valid_count = 0;
        in_credit_count = 0;
        grants_seen = 0;
        exp_q.delete();
        rst_n = 1'b1;
    endtask

    task automatic random_window(output window_t w);
        for (int i = 0; i < WIN_PIX; i++) begin
            next_rand();
            w[i] = rng_state[7:0];
        end
    endtask

    // spends one input credit, waits while none is left
    task automatic send_window(input window_t w, input blockset_t exp);
        while (windows_sent - in_credit_count >= FIFO_DEPTH) begin
            next_cycle();
        end
        in_valid = 1'b1;
        pix_in = w;
        exp_q.push_back(exp);
        windows_sent++;
        next_cycle();
        in_valid = 1'b0;
    endtask

    // every queued result has come out
    task automatic wait_for_drain();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
    endtask

    // compare process, outputs are registered so the edge sees last cycle's values
    always @(posedge clk) begin
        if (rst_n) begin
            if (out_valid) begin
                if (valid_count >= grants_seen) begin
                    fail_with("out_valid pulsed with no output credit outstanding");
                end
                if (exp_q.size() == 0) begin
                    fail_with("out_valid pulsed with no window pending");
                end
                check_block("block_out", block_out, exp_q.pop_front());
                valid_count++;
            end
            if (in_credit) begin
                if (in_credit_count >= valid_count) begin
                    fail_with("in_credit pulsed before a result was delivered");
                end
                in_credit_count++;
            end
            if (out_credit) begin
                grants_seen++;
            end
        end
    end

    initial begin
        window_t   w;
        blockset_t e;
        int        gap;
        rst_n = 1'b0;
        in_valid = 1'b0;
        pix_in = '0;
        out_credit = 1'b0;
        apply_reset();

        // quiet outputs after reset, credits still granted
        grant_mode = GRANT_ALWAYS;
        repeat (10) begin
            next_cycle();
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("in_credit", in_credit, 1'b0);
        end

        w = {WIN_PIX{8'h5a}};
        e = {NUM_BLOCKS*BLK_OUT*BLK_OUT{8'h5a}};
        send_window(w, e);
        w = {WIN_PIX{8'h20}};
        w[WIN_PIX-1-(2*WIN_COLS+7)] = 8'hff;   // impulse at (2,7)
        e = {NUM_BLOCKS*BLK_OUT*BLK_OUT{8'h20}};
        send_window(w, e);
        w = {WIN_PIX{8'h20}};
        w[WIN_PIX-1] = 8'hff;                  // impulse at the corner
        send_window(w, e);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_window(w);
            send_window(w, ref_denoise(w));
        end
        wait_for_drain();

        // back-pressure, fresh reset clears the leftover credits
        apply_reset();
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            random_window(w);
            send_window(w, ref_denoise(w));
        end
        repeat (12) next_cycle();
        check_count("out_valid pulses", valid_count, 0);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            grant_once = 1'b1;
            next_cycle();
            while (valid_count < i + 1) begin
                next_cycle();
            end
            repeat (5) next_cycle();
            check_count("out_valid pulses", valid_count, i + 1);
        end
        check_count("in_credit pulses", in_credit_count, FIFO_DEPTH);

        grant_mode = GRANT_RANDOM;
        for (int i = 0; i < NUM_GAPPED; i++) begin
            next_rand();
            gap = int'(rng_state[1:0]);
            repeat (gap) next_cycle();
            random_window(w);
            send_window(w, ref_denoise(w));
        end
        wait_for_drain();
        repeat (5) next_cycle();
        check_count("in_credit pulses", in_credit_count, valid_count);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+test
rtl/pixel_pkg.sv
rtl/flow_pkg.sv
rtl/result_fifo.sv
rtl/row_median_stage.sv
rtl/col_median_stage.sv
rtl/denoise_ctrl.sv
rtl/denoise_top.sv
test/tb_denoise.sv
